//--- rtl/lcdDraw_consts.svh
`ifndef LCDDRAW_CONSTS_SVH
`define LCDDRAW_CONSTS_SVH

////////////////////////////////////////
// Screen geometry.
////////////////////////////////////////
`define SCREEN_W        16                          // 800 on the real panel.
`define SCREEN_H        8                           // 480 on the real panel.
`define PIXEL_COUNT     (`SCREEN_W * `SCREEN_H)
`define PIXEL_X_BITS    ($clog2(`SCREEN_W))         // Column counter width.
`define BAR_COUNT       8

////////////////////////////////////////
// SDRAM address layout.
////////////////////////////////////////
`define BANK_BITS       2
`define ROW_BITS        13
`define COL_BITS        9
`define SDRAM_ADDR_BITS (`BANK_BITS + `ROW_BITS + `COL_BITS)

////////////////////////////////////////
// RGB565 colours, in bar order.
////////////////////////////////////////
`define COLOR_RED       16'hF800
`define COLOR_GREEN     16'h07E0
`define COLOR_BLUE      16'h001F                    // Also the clear colour.
`define COLOR_WHITE     16'hFFFF
`define COLOR_BLACK     16'h0000
`define COLOR_YELLOW    16'hFFE0
`define COLOR_CYAN      16'h07FF
`define COLOR_MAGENTA   16'hF81F

`endif

//--- rtl/lcdDrawPkg.sv
`include "lcdDraw_consts.svh"

package lcdDrawPkg;

    ////////////////////////////////////////
    // Draw commands.
    ////////////////////////////////////////
    // Value 2 stays free for the sine wave.
    typedef enum logic [1:0] {
        cmdClear = 2'd0,    // Fill with the clear colour.
        cmdImage = 2'd1     // Fixed colour bars.
    } drawCmd_e;

    ////////////////////////////////////////
    // SDRAM address word.
    ////////////////////////////////////////
    typedef struct packed {
        logic [`BANK_BITS-1:0] bank;
        logic [`ROW_BITS-1:0]  row;
        logic [`COL_BITS-1:0]  col;
    } sdramBrc_t;

    // Same 24 bits, read two ways.
    typedef union packed {
        logic [`SDRAM_ADDR_BITS-1:0] linear;      // Pixel index, counted by the core.
        sdramBrc_t                   bankRowCol;  // Controller view.
    } sdramAddr_u;

    ////////////////////////////////////////
    // Write request bundle.
    ////////////////////////////////////////
    typedef struct packed {
        logic       req;    // Held until wrDone.
        sdramAddr_u addr;
        logic [15:0] data;  // RGB565 pixel.
    } sdramWrReq_t;

endpackage

//--- rtl/pixelPattern.sv
`include "lcdDraw_consts.svh"

module pixelPattern (
    input  logic [`PIXEL_X_BITS-1:0] pixelX,    // Current column.
    output logic [15:0]              barColor   // Colour of that column.
);

    // Width of one bar in pixels.
    localparam logic [`PIXEL_X_BITS-1:0] BarW =
        `PIXEL_X_BITS'(`SCREEN_W / `BAR_COUNT);
    localparam int BarIdxBits = $clog2(`BAR_COUNT);

    logic [`PIXEL_X_BITS-1:0] barQuot;          // Column over bar width.
    logic [BarIdxBits-1:0]    barIdx;

    ////////////////////////////////////////
    // Column to bar index.
    ////////////////////////////////////////
    // Constant divisor, so this folds to shifts on the small screen.
    assign barQuot = pixelX / BarW;
    assign barIdx  = barQuot[BarIdxBits-1:0];   // Eight bars fit in three bits.

    ////////////////////////////////////////
    // Bar index to colour.
    ////////////////////////////////////////
    always_comb begin
        case (barIdx)
            3'd0:    barColor = `COLOR_RED;
            3'd1:    barColor = `COLOR_GREEN;
            3'd2:    barColor = `COLOR_BLUE;
            3'd3:    barColor = `COLOR_WHITE;
            3'd4:    barColor = `COLOR_BLACK;
            3'd5:    barColor = `COLOR_YELLOW;
            3'd6:    barColor = `COLOR_CYAN;
            default: barColor = `COLOR_MAGENTA;  // Last bar.
        endcase
    end

endmodule

//--- rtl/drawCore.sv
`include "lcdDraw_consts.svh"

module drawCore (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     coreEn,    // Run level from the adapter.
    input  lcdDrawPkg::drawCmd_e     coreCmd,   // Clear or image.
    output logic                     coreDone,  // One pulse per finished frame.
    output logic [`PIXEL_X_BITS-1:0] pixelX,    // Column of the pixel in flight.
    input  logic [15:0]              barColor,  // From the pattern generator.
    output lcdDrawPkg::sdramWrReq_t  sdramWr,
    input  logic                     wrDone     // Controller accepted the write.
);

    localparam logic [`SDRAM_ADDR_BITS-1:0] LastAddr =
        `SDRAM_ADDR_BITS'(`PIXEL_COUNT - 1);
    localparam logic [`PIXEL_X_BITS-1:0] LastCol =
        `PIXEL_X_BITS'(`SCREEN_W - 1);

    typedef enum logic [1:0] {
        stIdle,     // Wait for coreEn.
        stRequest,  // req high, wait for wrDone.
        stAdvance,  // One low cycle between writes.
        stFinish    // Frame done, wait for coreEn to drop.
    } coreState_e;

    coreState_e               state;
    logic                     reqQ;
    lcdDrawPkg::sdramAddr_u   addrQ;
    logic [`PIXEL_X_BITS-1:0] colQ;             // Runs beside addrQ, no divide.
    logic [15:0]              pixData;

    ////////////////////////////////////////
    // Pixel data select.
    ////////////////////////////////////////
    always_comb begin
        case (coreCmd)
            lcdDrawPkg::cmdClear: pixData = `COLOR_BLUE;
            default:              pixData = barColor;
        endcase
    end

    ////////////////////////////////////////
    // Scan FSM.
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= stIdle;
            reqQ     <= 1'b0;
            addrQ    <= '0;
            colQ     <= '0;
            coreDone <= 1'b0;
        end else begin
            coreDone <= 1'b0;                   // Pulse by default.
            case (state)
                stIdle: begin
                    if (coreEn) begin           // Fresh start from pixel 0.
                        addrQ.linear <= '0;
                        colQ         <= '0;
                        reqQ         <= 1'b1;
                        state        <= stRequest;
                    end
                end
                stRequest: begin
                    if (wrDone) begin
                        reqQ         <= 1'b0;
                        addrQ.linear <= addrQ.linear + 1'b1;
                        colQ         <= (colQ == LastCol) ? '0 : colQ + 1'b1;
                        if (addrQ.linear == LastAddr) begin
                            coreDone <= 1'b1;   // Last pixel written.
                            state    <= stFinish;
                        end else begin
                            state    <= stAdvance;
                        end
                    end
                end
                stAdvance: begin
                    reqQ  <= 1'b1;              // Next pixel.
                    state <= stRequest;
                end
                default: begin
                    if (!coreEn) state <= stIdle;  // Need a fresh rising edge.
                end
            endcase
        end
    end

    assign pixelX       = colQ;
    assign sdramWr.req  = reqQ;
    assign sdramWr.addr = addrQ;
    assign sdramWr.data = pixData;              // Stable while colQ holds.

endmodule

//--- rtl/drawAdapter.sv
module drawAdapter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,            // Low freezes the sequencer.
    output logic                 drawInitReady, // Power-on image is in SDRAM.
    input  logic                 drawSchedule,  // Request from the display side.
    output logic                 drawDone,      // One-cycle answer.
    output logic                 led,           // Heartbeat.
    output logic                 coreEn,
    output lcdDrawPkg::drawCmd_e coreCmd,
    input  logic                 coreDone
);

    // Step numbers.
    localparam logic [2:0] StepReserve = 3'd0;
    localparam logic [2:0] StepClear   = 3'd1;
    localparam logic [2:0] StepImage   = 3'd2;
    localparam logic [2:0] StepReady   = 3'd3;
    localparam logic [2:0] StepWait    = 3'd4;
    localparam logic [2:0] StepPulse   = 3'd5;
    localparam logic [2:0] StepReturn  = 3'd6;

    logic [2:0] step;
    logic       pendingDone;                    // coreDone seen while en was low.
    logic       coreFinished;

    ////////////////////////////////////////
    // Catch a frame end during a freeze.
    ////////////////////////////////////////
    assign coreFinished = coreDone | pendingDone;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) pendingDone <= 1'b0;
        else        pendingDone <= ~en & coreFinished;  // Consumed once en is back.
    end

    ////////////////////////////////////////
    // Step sequencer.
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step          <= StepReserve;
            coreEn        <= 1'b0;
            coreCmd       <= lcdDrawPkg::cmdClear;
            drawInitReady <= 1'b0;
            drawDone      <= 1'b0;
            led           <= 1'b0;
        end else if (en) begin
            case (step)
                StepReserve: step <= StepClear;  // Let the SDRAM side settle.
                StepClear: begin
                    if (coreFinished) begin
                        coreEn <= 1'b0;
                        step   <= StepImage;
                    end else begin
                        coreEn  <= 1'b1;
                        coreCmd <= lcdDrawPkg::cmdClear;
                    end
                end
                StepImage: begin
                    if (coreFinished) begin
                        coreEn <= 1'b0;
                        step   <= StepReady;
                    end else begin
                        coreEn  <= 1'b1;
                        coreCmd <= lcdDrawPkg::cmdImage;
                    end
                end
                StepReady: begin
                    drawInitReady <= 1'b1;      // Sticky until reset.
                    step          <= StepWait;
                end
                StepWait: if (drawSchedule) step <= StepPulse;
                StepPulse: begin
                    drawDone <= 1'b1;
                    led      <= ~led;           // Toggle per answer.
                    step     <= StepReturn;
                end
                StepReturn: begin
                    drawDone <= 1'b0;
                    step     <= StepWait;
                end
                default: step <= StepWait;      // Unused code 7.
            endcase
        end
    end

endmodule

//--- rtl/lcdDrawTop.sv
`include "lcdDraw_consts.svh"

module lcdDrawTop (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    en,
    input  logic                    drawSchedule,
    input  logic                    wrDone,         // From the SDRAM controller.
    output logic                    drawInitReady,
    output logic                    drawDone,
    output logic                    led,
    output lcdDrawPkg::sdramWrReq_t sdramWr         // To the SDRAM controller.
);

    ////////////////////////////////////////
    // Internal wires.
    ////////////////////////////////////////
    logic                     coreEn;
    lcdDrawPkg::drawCmd_e     coreCmd;
    logic                     coreDone;
    logic [`PIXEL_X_BITS-1:0] pixelX;
    logic [15:0]              barColor;

    // Sequencer.
    drawAdapter drawAdapter_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .drawInitReady (drawInitReady),
        .drawSchedule  (drawSchedule),
        .drawDone      (drawDone),
        .led           (led),
        .coreEn        (coreEn),
        .coreCmd       (coreCmd),
        .coreDone      (coreDone)
    );

    // Pixel writer.
    drawCore drawCore_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .coreEn   (coreEn),
        .coreCmd  (coreCmd),
        .coreDone (coreDone),
        .pixelX   (pixelX),
        .barColor (barColor),
        .sdramWr  (sdramWr),
        .wrDone   (wrDone)
    );

    pixelPattern pixelPattern_inst (
        .pixelX   (pixelX),
        .barColor (barColor)            // Same-cycle lookup.
    );

endmodule

//--- sim/clockGen.sv
module clockGen (
    output logic clk                    // Free-running testbench clock.
);
    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;
    always #2 clk = ~clk;               // 4 ns period.

endmodule

//--- sim/lcdDraw_props.sv
`include "lcdDraw_consts.svh"

module lcdDraw_props (
    input logic                     clk,
    input logic                     rst_n,
    input lcdDrawPkg::sdramWrReq_t  sdramWr,
    input logic                     wrDone,
    input logic [`PIXEL_X_BITS-1:0] pixelX,
    input logic                     coreEn,
    input logic                     coreDone
);
    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;                  // Read by the testbench at the end.

    ////////////////////////////////////////
    // Write handshake.
    ////////////////////////////////////////
    holdUntilDone: assert property (@(posedge clk) disable iff (!rst_n)
        sdramWr.req && !wrDone |=> sdramWr.req && $stable(sdramWr.addr.linear)
                                    && $stable(sdramWr.data))
        else begin failCount++; $error("write request moved before wrDone"); end

    dropAfterDone: assert property (@(posedge clk) disable iff (!rst_n)
        sdramWr.req && wrDone |=> !sdramWr.req)
        else begin failCount++; $error("req still high after wrDone"); end

    advanceAfterDone: assert property (@(posedge clk) disable iff (!rst_n)
        sdramWr.req && wrDone |=> sdramWr.addr.linear == $past(sdramWr.addr.linear) + 1'b1)
        else begin failCount++; $error("address did not advance after wrDone"); end

    // Controller view of the same word.
    colFieldMatch: assert property (@(posedge clk) disable iff (!rst_n)
        sdramWr.req |-> sdramWr.addr.bankRowCol.col[`PIXEL_X_BITS-1:0] == pixelX
                        && sdramWr.addr.bankRowCol.bank == '0)
        else begin failCount++; $error("column field does not match pixelX"); end

    ////////////////////////////////////////
    // Frame end and adapter reaction.
    ////////////////////////////////////////
    donePulse: assert property (@(posedge clk) disable iff (!rst_n)
        coreDone |=> !coreDone && !coreEn)
        else begin failCount++; $error("coreDone too long or coreEn kept"); end

endmodule

//--- sim/lcdDrawTb.sv
`include "lcdDraw_consts.svh"

module lcdDrawTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned RandSeed = 32'hbeaa_5c93;
    localparam int InitTimeout = 2 * `PIXEL_COUNT * 12;   // Worst latency plus slack.
    localparam int DoneTimeout = 10;

    logic clk, rst_n, en, drawSchedule, wrDone;
    logic drawInitReady, drawDone, led;
    lcdDrawPkg::sdramWrReq_t sdramWr;

    int latQ[$], schedQ[$], enQ[$], pixAddrQ[$], pixColorQ[$];
    logic [15:0] frameMem [int];        // Indexed by linear address.
    int writeCount = 0;
    int checkCount = 0, errorCount = 0, testCount = 0, failedTests = 0;

    clockGen clockGen_inst (.clk(clk));

    lcdDrawTop lcdDrawTop_inst (.*);

    bind drawCore lcdDraw_props lcdDraw_props_inst (.*);

    ////////////////////////////////////////
    // Helpers.
    ////////////////////////////////////////
    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic reportTest(input string name, input int errsAtStart);
        testCount++;
        if (errorCount == errsAtStart) begin
            $display("test %s: passed", name);
        end else begin
            failedTests++;
            $display("test %s: failed with %0d errors", name, errorCount - errsAtStart);
        end
    endtask

    // Column over bar width picks the bar from red to magenta.
    function automatic logic [15:0] expectedBar(input int addr);
        case ((addr % `SCREEN_W) / (`SCREEN_W / `BAR_COUNT))
            0: return `COLOR_RED;
            1: return `COLOR_GREEN;
            2: return `COLOR_BLUE;
            3: return `COLOR_WHITE;
            4: return `COLOR_BLACK;
            5: return `COLOR_YELLOW;
            6: return `COLOR_CYAN;
            default: return `COLOR_MAGENTA;
        endcase
    endfunction

    function automatic int nextLatency();
        if (latQ.size() > 0) return latQ.pop_front();
        return int'($urandom % 4);          // Random 0 to 3 cycles once the trace is used up.
    endfunction

    task automatic loadTrace();
        int fd, code, n, v, a;
        string key, line;
        fd = $fopen("sim/lcdDraw_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open trace file sim/lcdDraw_trace.txt");
            errorCount++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", key);
            if (code != 1) break;
            if (key == "#") begin
                code = $fgets(line, fd);    // Comment line.
            end else if (key == "LAT") begin
                code = $fscanf(fd, "%d", n);
                repeat (n) begin
                    code = $fscanf(fd, "%d", v);
                    latQ.push_back(v);
                end
            end else if (key == "SCHED") begin
                code = $fscanf(fd, "%d", v);
                schedQ.push_back(v);
            end else if (key == "EN") begin
                code = $fscanf(fd, "%d", v);
                enQ.push_back(v);
            end else if (key == "PIX") begin
                code = $fscanf(fd, "%d %h", a, v);
                pixAddrQ.push_back(a);
                pixColorQ.push_back(v);
            end else begin
                $display("Trace has an unknown keyword %s", key);
                errorCount++;
                code = $fgets(line, fd);
            end
        end
        $fclose(fd);
    endtask

    // Strobe for one cycle and count edges until drawDone shows.
    task automatic sendStrobe(output int edges);
        @(posedge clk);
        drawSchedule <= 1'b1;
        edges = 0;
        @(negedge clk);
        while (drawDone !== 1'b1 && edges < DoneTimeout) begin
            @(posedge clk);
            drawSchedule <= 1'b0;
            edges++;
            @(negedge clk);
        end
        if (drawDone !== 1'b1) begin
            $display("Timeout: no drawDone within %0d cycles of a strobe", DoneTimeout);
            errorCount++;
        end
    endtask

    ////////////////////////////////////////
    // SDRAM write port model.
    ////////////////////////////////////////
    initial begin : sdramModel
        bit          pending;
        int          latLeft;
        logic        seenReq;
        int          seenAddr;
        logic [15:0] seenData;
        pending = 1'b0;
        latLeft = 0;
        wrDone <= 1'b0;
        void'($urandom(RandSeed));
        forever begin
            @(negedge clk);                 // Request settled.
            seenReq  = sdramWr.req;
            seenAddr = 32'(sdramWr.addr.linear);
            seenData = sdramWr.data;
            @(posedge clk);
            if (wrDone) begin               // Accepted at this edge.
                wrDone <= 1'b0;
                pending = 1'b0;
                if (seenReq) begin
                    if (writeCount < `PIXEL_COUNT) begin
                        checkValue("clear addr", 32'(seenAddr), writeCount);
                        checkValue("clear data", 32'(seenData), 32'(`COLOR_BLUE));
                    end
                    if (seenAddr >= `PIXEL_COUNT) begin
                        $display("Write to address %0d lies outside the screen", seenAddr);
                        errorCount++;
                    end
                    frameMem[seenAddr] = seenData;
                    writeCount++;
                end
            end else if (seenReq) begin
                if (!pending) begin
                    pending = 1'b1;
                    latLeft = nextLatency();
                end
                if (latLeft == 0) wrDone <= 1'b1;
                else latLeft--;
            end
        end
    end

    ////////////////////////////////////////
    // Test sequence.
    ////////////////////////////////////////
    initial begin : mainFlow
        int errsAtStart, cycles, edges, hold, sawDone, i;
        logic ledModel;
        rst_n        <= 1'b0;
        en           <= 1'b1;
        drawSchedule <= 1'b0;
        ledModel     = 1'b0;                // Heartbeat starts low.
        loadTrace();
        for (i = 0; i < `PIXEL_COUNT; i++) frameMem[i] = 16'hC000 | 16'(i);  // Never a colour.
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        errsAtStart = errorCount;           // Outputs idle after reset.
        @(negedge clk);
        checkValue("drawInitReady", 32'(drawInitReady), 0);
        checkValue("drawDone", 32'(drawDone), 0);
        checkValue("led", 32'(led), 0);
        checkValue("sdramWr.req", 32'(sdramWr.req), 0);
        reportTest("reset", errsAtStart);

        errsAtStart = errorCount;           // Clear, then image, then ready.
        cycles = 0;
        while (drawInitReady !== 1'b1 && cycles < InitTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (drawInitReady !== 1'b1) begin
            $display("Timeout: drawInitReady still low after %0d cycles", cycles);
            errorCount++;
        end
        checkValue("writes before drawInitReady", writeCount, 2 * `PIXEL_COUNT);
        reportTest("clear phase", errsAtStart);

        errsAtStart = errorCount;
        foreach (pixAddrQ[k])
            checkValue($sformatf("frameMem[%0d]", pixAddrQ[k]),
                       32'(frameMem[pixAddrQ[k]]), pixColorQ[k]);
        for (i = 0; i < `PIXEL_COUNT; i++)
            checkValue($sformatf("frameMem[%0d]", i), 32'(frameMem[i]), 32'(expectedBar(i)));
        reportTest("image phase", errsAtStart);

        errsAtStart = errorCount;           // One answer per strobe.
        foreach (schedQ[k]) begin
            repeat (schedQ[k]) @(posedge clk);
            sendStrobe(edges);
            ledModel = !ledModel;           // Toggles with every answer.
            checkValue("drawDone delay", edges, 2);
            checkValue("led", 32'(led), 32'(ledModel));
            @(negedge clk);
            checkValue("drawDone width", 32'(drawDone), 0);
        end
        reportTest("schedule", errsAtStart);

        errsAtStart = errorCount;           // Frozen adapter ignores the strobe.
        foreach (enQ[k]) begin
            hold = (enQ[k] < 1) ? 1 : enQ[k];
            sawDone = 0;
            @(posedge clk);
            en <= 1'b0;
            drawSchedule <= 1'b1;
            for (i = 0; i < hold + 4; i++) begin
                @(posedge clk);
                drawSchedule <= 1'b0;
                if (i == hold - 1) en <= 1'b1;
                @(negedge clk);
                if (drawDone === 1'b1) sawDone++;
            end
            checkValue("drawDone while en low", sawDone, 0);
            checkValue("led while en low", 32'(led), 32'(ledModel));
            sendStrobe(edges);
            ledModel = !ledModel;
            checkValue("drawDone delay after en", edges, 2);
            checkValue("led after en", 32'(led), 32'(ledModel));
            @(negedge clk);
        end
        reportTest("enable hold", errsAtStart);

        errsAtStart = errorCount;
        checkValue("assertion failures",
                   lcdDrawTop_inst.drawCore_inst.lcdDraw_props_inst.failCount, 0);
        checkValue("total writes", writeCount, 2 * `PIXEL_COUNT);
        reportTest("handshake", errsAtStart);

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 testCount, failedTests, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- sim/lcdDraw_trace.txt
# KEY values: LAT count then wrDone latencies in cycles, SCHED idle cycles before a strobe
# EN cycles with en held low around a strobe, PIX linear address and expected RGB565 in hex
LAT 8 0 1 2 3 0 5 1 0
LAT 6 4 0 0 2 1 3
LAT 4 2 2 0 1
SCHED 0
SCHED 3
SCHED 7
SCHED 1
EN 3
EN 1
PIX 0 F800
PIX 19 07E0
PIX 37 001F
PIX 54 FFFF
PIX 72 0000
PIX 91 FFE0
PIX 108 07FF
PIX 127 F81F
PIX 46 F81F
PIX 120 0000

//--- build.f
+incdir+rtl
rtl/lcdDrawPkg.sv
rtl/pixelPattern.sv
rtl/drawCore.sv
rtl/drawAdapter.sv
rtl/lcdDrawTop.sv
sim/clockGen.sv
sim/lcdDraw_props.sv
sim/lcdDrawTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= lcdDrawTb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= NO ERRORS

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
